//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

   // widths with a meaning of their own
   typedef logic [2:0]   seg_id_t;
   typedef logic [2:0]   reg_id_t;
   typedef logic [127:0] instr_bytes_t;
   typedef logic [31:0]  addr_t;
   typedef logic [47:0]  offset_t;
   typedef logic [2:0]   aluk_t;
   typedef logic [15:0]  sel_t;
   typedef logic [3:0]   len_t;

   // segment register encodings
   localparam seg_id_t SEG_ES = 3'd0;
   localparam seg_id_t SEG_CS = 3'd1;
   localparam seg_id_t SEG_SS = 3'd2;
   localparam seg_id_t SEG_DS = 3'd3;
   localparam seg_id_t SEG_FS = 3'd4;
   localparam seg_id_t SEG_GS = 3'd5;

   // operand sizes as carried by data_size
   localparam logic [1:0] DSIZE_8  = 2'b00;
   localparam logic [1:0] DSIZE_16 = 2'b01;
   localparam logic [1:0] DSIZE_32 = 2'b10;
   localparam logic [1:0] DSIZE_64 = 2'b11;

   localparam aluk_t   ALU_ADD = 3'd0;
   localparam aluk_t   ALU_SUB = 3'd5;
   localparam reg_id_t REG_ESP = 3'd4;
   localparam logic [1:0] MOD_REG = 2'b11;

   // opcode bytes; the 0F page ones need opcode_size set
   localparam logic [7:0] OP_ESC     = 8'h0F;
   localparam logic [7:0] OP_ADD_RM  = 8'h01;
   localparam logic [7:0] OP_GRP1    = 8'h81;
   localparam logic [7:0] OP_MOV_RM  = 8'h89;
   localparam logic [7:0] OP_PUSH_ES = 8'h06;
   localparam logic [7:0] OP_POP_DS  = 8'h1F;
   localparam logic [7:0] OP_JMP_FAR = 8'hEA;
   localparam logic [7:0] OP_MOVQ    = 8'h7F;
   localparam logic [7:0] OP_CMPXCHG = 8'hB0;

   // what stage one hands over
   typedef struct packed {
      logic [15:0] opcode;
      logic        opcode_size;
      logic        operand_override;
      logic        segment_override;
      seg_id_t     seg_id;
      logic        modrm_present;
      logic [7:0]  modrm;
      logic        sib_present;
      logic [7:0]  sib;
      logic        disp_present;
      logic        disp_size;
      logic [2:0]  disp_sel;
      logic [1:0]  imm_size;
      logic [3:0]  imm_sel;
      logic [2:0]  offset_sel;
      logic [1:0]  offset_size;
      len_t        instr_length;
   } d1_fields_t;

   // microcode word; a set mux_* bit means the word value is used as is
   typedef struct packed {
      logic [1:0] data_size;
      logic       sr1_needed;
      logic       seg1_needed;
      logic       mux_seg1_needed;
      logic       mm1_needed;
      logic       mem_rd;
      logic       mux_mem_rd;
      logic       mem_wr;
      logic       mux_mem_wr;
      aluk_t      aluk;
      logic       mux_aluk;
      logic       ld_gpr1;
      logic       mux_ld_gpr1;
      logic       ld_mm;
      reg_id_t    sr1;
      logic       mux_sr1;
      reg_id_t    sr2;
      logic       mux_sr2;
      logic       mux_seg1;
      logic       mux_seg2;
   } cs_word_t;

   // resolved controls for address generation and later
   typedef struct packed {
      logic [1:0] data_size;
      logic       sr1_needed;
      logic       seg1_needed;
      logic       mm1_needed;
      logic       mem_rd;
      logic       mem_wr;
      aluk_t      aluk;
      logic       ld_gpr1;
      logic       ld_mm;
      reg_id_t    sr1;
      reg_id_t    sr2;
      reg_id_t    sr3;
      reg_id_t    sr4;
      seg_id_t    seg1;
      seg_id_t    seg2;
      logic       sib_en;
      logic       disp_en;
      logic       base_reg_en;
      logic       mux_seg;
      logic       cmpxchg;
      logic [1:0] sib_scale;
   } ag_ctrl_t;

   typedef struct packed {
      ag_ctrl_t ctrl;
      addr_t    eip;
      sel_t     cs;
      addr_t    imm32;
      addr_t    disp32;
      offset_t  offset;
   } d2_out_t;

endpackage

`default_nettype wire

//--- design/ucontrol_store.sv
`timescale 1ns/1ps
`default_nettype none

module ucontrol_store (
   input  logic [7:0]           opcode,
   input  logic                 opcode_size,
   output decode_pkg::cs_word_t word
);
   import decode_pkg::*;

   // unlisted opcodes get an all-zero word
   always_comb begin
      word = '0;
      case ({opcode_size, opcode})
         {1'b0, OP_ADD_RM}: begin
            word.data_size  = DSIZE_32;
            word.sr1_needed = 1'b1;
            word.aluk       = ALU_ADD;
            word.mux_aluk   = 1'b1;
         end
         // alu op comes from the reg field
         {1'b0, OP_GRP1}: begin
            word.data_size  = DSIZE_32;
            word.sr1_needed = 1'b1;
            word.mux_sr2    = 1'b1;
         end
         {1'b0, OP_MOV_RM}: begin
            word.data_size  = DSIZE_32;
            word.sr1_needed = 1'b1;
            word.mux_mem_rd = 1'b1;
            word.aluk       = ALU_ADD;
            word.mux_aluk   = 1'b1;
         end
         // esp based, stack write
         {1'b0, OP_PUSH_ES}: begin
            word.data_size       = DSIZE_32;
            word.sr1_needed      = 1'b1;
            word.seg1_needed     = 1'b1;
            word.mux_seg1_needed = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.mem_wr          = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.aluk            = ALU_SUB;
            word.mux_aluk        = 1'b1;
            word.ld_gpr1         = 1'b1;
            word.mux_ld_gpr1     = 1'b1;
            word.sr1             = REG_ESP;
            word.mux_sr1         = 1'b1;
            word.mux_sr2         = 1'b1;
         end
         {1'b0, OP_POP_DS}: begin
            word.data_size       = DSIZE_32;
            word.sr1_needed      = 1'b1;
            word.seg1_needed     = 1'b1;
            word.mux_seg1_needed = 1'b1;
            word.mem_rd          = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.aluk            = ALU_ADD;
            word.mux_aluk        = 1'b1;
            word.ld_gpr1         = 1'b1;
            word.mux_ld_gpr1     = 1'b1;
            word.sr1             = REG_ESP;
            word.mux_sr1         = 1'b1;
            word.mux_sr2         = 1'b1;
         end
         // no modrm, pointer comes from the offset field
         {1'b0, OP_JMP_FAR}: begin
            word.data_size       = DSIZE_32;
            word.mux_seg1_needed = 1'b1;
            word.mux_mem_rd      = 1'b1;
            word.mux_mem_wr      = 1'b1;
            word.mux_aluk        = 1'b1;
            word.mux_ld_gpr1     = 1'b1;
            word.mux_sr1         = 1'b1;
            word.mux_sr2         = 1'b1;
         end
         {1'b1, OP_MOVQ}: begin
            word.data_size   = DSIZE_64;
            word.mm1_needed  = 1'b1;
            word.mux_mem_rd  = 1'b1;
            word.mux_aluk    = 1'b1;
            word.mux_ld_gpr1 = 1'b1;
         end
         {1'b1, OP_CMPXCHG},
         {1'b1, OP_CMPXCHG[7:1], 1'b1}: begin
            word.data_size  = opcode[0] ? DSIZE_32 : DSIZE_8;
            word.sr1_needed = 1'b1;
            word.aluk       = ALU_SUB;
            word.mux_aluk   = 1'b1;
         end
         default: word = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/field_extract.sv
`timescale 1ns/1ps
`default_nettype none

module field_extract (
   input  decode_pkg::instr_bytes_t ir,
   input  decode_pkg::d1_fields_t   d1,
   output decode_pkg::addr_t        disp32,
   output decode_pkg::addr_t        imm32,
   output decode_pkg::offset_t      offset
);
   import decode_pkg::*;

   instr_bytes_t disp_win;
   instr_bytes_t imm_win;
   instr_bytes_t off_win;

   // shift each field down so its first byte sits at bit 0
   assign disp_win = ir >> {d1.disp_sel, 3'b000};
   assign imm_win  = ir >> {d1.imm_sel, 3'b000};
   assign off_win  = ir >> {d1.offset_sel, 3'b000};

   // disp8 is sign extended, disp32 is little endian
   always_comb begin
      if (!d1.disp_present) begin
         disp32 = '0;
      end else if (d1.disp_size) begin
         disp32 = disp_win[31:0];
      end else begin
         disp32 = {{24{disp_win[7]}}, disp_win[7:0]};
      end
   end

   always_comb begin
      case (d1.imm_size)
         2'd0:    imm32 = {{24{imm_win[7]}}, imm_win[7:0]};
         2'd1:    imm32 = {{16{imm_win[15]}}, imm_win[15:0]};
         default: imm32 = imm_win[31:0];
      endcase
   end

   // far pointer: 4 offset bytes, then the 2 selector bytes
   always_comb begin
      if (d1.offset_size != 2'd0) begin
         offset = {off_win[47:32], off_win[31:0]};
      end else begin
         offset = '0;
      end
   end

endmodule

`default_nettype wire

//--- design/segment_select.sv
`timescale 1ns/1ps
`default_nettype none

module segment_select (
   input  decode_pkg::d1_fields_t d1,
   output decode_pkg::seg_id_t    seg1_id
);
   import decode_pkg::*;

   logic [1:0] mod;
   logic [2:0] rm;
   logic [7:0] op;
   logic       push_pop_seg;
   logic       stack_base;

   assign mod = d1.modrm[7:6];
   assign rm  = d1.modrm[2:0];
   assign op  = d1.opcode[7:0];

   // 06 07 0E 16 17 1E 1F, i.e. 000x x11x on page one minus the 0F escape
   assign push_pop_seg = !d1.opcode_size && (op[7:5] == 3'b000)
                         && (op[2:1] == 2'b11) && (op != OP_ESC);

   // ebp based with a displacement, or esp as sib base
   assign stack_base = (d1.modrm_present && (mod == 2'b01 || mod == 2'b10) && rm == 3'b101)
                       || (d1.sib_present && d1.sib[2:0] == 3'b100);

   always_comb begin
      if (d1.segment_override) begin
         seg1_id = d1.seg_id;
      end else if (push_pop_seg) begin
         // segment encoded in opcode bits 5:3
         seg1_id = op[5:3];
      end else if (stack_base) begin
         seg1_id = SEG_SS;
      end else begin
         seg1_id = SEG_DS;
      end
   end

endmodule

`default_nettype wire

//--- design/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control (
   input  decode_pkg::d1_fields_t d1,
   input  decode_pkg::cs_word_t   word,
   input  decode_pkg::seg_id_t    seg1_id,
   output decode_pkg::ag_ctrl_t   ctrl
);
   import decode_pkg::*;

   logic [1:0] mod;
   reg_id_t    reg_op;
   reg_id_t    rm;
   reg_id_t    base_reg;
   logic       mem_form;
   logic       reg_form;
   logic       op_movq;
   logic       op_cmpxchg;

   assign mod    = d1.modrm[7:6];
   assign reg_op = d1.modrm[5:3];
   assign rm     = d1.modrm[2:0];

   assign mem_form = (mod != MOD_REG);
   assign reg_form = (mod == MOD_REG);

   // full 16-bit compares, escape byte included
   assign op_movq    = (d1.opcode == {OP_ESC, OP_MOVQ});
   assign op_cmpxchg = ({d1.opcode[15:1], 1'b0} == {OP_ESC, OP_CMPXCHG});

   // sib base wins over rm when a sib byte exists
   assign base_reg = d1.sib_present ? d1.sib[2:0] : rm;

   always_comb begin
      ctrl.data_size   = d1.operand_override ? DSIZE_16 : word.data_size;
      ctrl.seg1_needed = word.mux_seg1_needed ? word.seg1_needed : mem_form;
      ctrl.mem_rd      = word.mux_mem_rd ? word.mem_rd : mem_form;
      ctrl.mem_wr      = word.mux_mem_wr ? word.mem_wr : mem_form;
      ctrl.aluk        = word.mux_aluk ? word.aluk : reg_op;
      ctrl.ld_gpr1     = word.mux_ld_gpr1 ? word.ld_gpr1 : reg_form;

      // mmx register vs memory forms
      ctrl.sr1_needed = word.sr1_needed | (word.mm1_needed & mem_form);
      ctrl.mm1_needed = word.mm1_needed & reg_form & !op_movq;
      ctrl.ld_mm      = word.ld_mm | (reg_form & op_movq);

      ctrl.sr1  = word.mux_sr1 ? word.sr1 : base_reg;
      ctrl.sr2  = word.mux_sr2 ? word.sr2 : reg_op;
      ctrl.sr3  = reg_op;
      ctrl.sr4  = d1.sib[5:3];
      ctrl.seg1 = word.mux_seg1 ? SEG_ES : seg1_id;
      ctrl.seg2 = word.mux_seg2 ? reg_op : SEG_SS;

      ctrl.sib_en    = d1.sib_present;
      ctrl.disp_en   = d1.disp_present;
      ctrl.sib_scale = d1.sib[7:6];
      // disp32 only, no base register
      ctrl.base_reg_en = (mod == 2'b00) && (rm == 3'b101);
      ctrl.mux_seg     = d1.segment_override && (d1.seg_id == SEG_CS);
      ctrl.cmpxchg     = op_cmpxchg;
   end

endmodule

`default_nettype wire

//--- design/d2_latch.sv
`timescale 1ns/1ps
`default_nettype none

module d2_latch (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                in_valid,
   input  logic                stall,
   input  decode_pkg::d2_out_t next,
   input  decode_pkg::len_t    length,
   output decode_pkg::d2_out_t out,
   output logic                out_valid
);
   import decode_pkg::*;

   addr_t eip_next;

   // fall-through eip, wraps at 2^32
   assign eip_next = next.eip + addr_t'(length);

   // stall holds both the payload and the valid bit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out       <= '0;
         out_valid <= 1'b0;
      end else if (!stall) begin
         out       <= next;
         out.eip   <= eip_next;
         out_valid <= in_valid;
      end
   end

endmodule

`default_nettype wire

//--- design/decode_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage2 (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     in_valid,
   input  logic                     stall,
   input  decode_pkg::d1_fields_t   d1,
   input  decode_pkg::instr_bytes_t ir,
   input  decode_pkg::addr_t        eip,
   input  decode_pkg::sel_t         cs,
   output decode_pkg::d2_out_t      out,
   output logic                     out_valid
);
   import decode_pkg::*;

   cs_word_t word;
   seg_id_t  seg1_id;
   ag_ctrl_t ctrl;
   addr_t    disp32;
   addr_t    imm32;
   offset_t  offset;
   d2_out_t  next;

   ucontrol_store u_ucontrol_store (
      .opcode      (d1.opcode[7:0]),
      .opcode_size (d1.opcode_size),
      .word        (word)
   );

   field_extract u_field_extract (
      .ir     (ir),
      .d1     (d1),
      .disp32 (disp32),
      .imm32  (imm32),
      .offset (offset)
   );

   segment_select u_segment_select (
      .d1      (d1),
      .seg1_id (seg1_id)
   );

   decode_control u_decode_control (
      .d1      (d1),
      .word    (word),
      .seg1_id (seg1_id),
      .ctrl    (ctrl)
   );

   // latch input bundle
   assign next = '{ctrl: ctrl, eip: eip, cs: cs, imm32: imm32,
                   disp32: disp32, offset: offset};

   d2_latch u_d2_latch (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .stall     (stall),
      .next      (next),
      .length    (d1.instr_length),
      .out       (out),
      .out_valid (out_valid)
   );

endmodule

`default_nettype wire

//--- test/tb_decode_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage2;
   import decode_pkg::*;

   localparam int N_INSTR = 400;
   // at most one stall cycle per instruction, plus reset and drain
   localparam int WATCHDOG_NS = (2 * N_INSTR + 40) * 10;

   logic         clk;
   logic         arst_n;
   logic         in_valid;
   logic         stall;
   d1_fields_t   d1;
   instr_bytes_t ir;
   addr_t        eip;
   sel_t         cs;
   d2_out_t      out;
   logic         out_valid;

   logic [31:0]  seed;
   int           cyc;
   int           checked;

   // reference copy of the instruction the latch should hold
   logic         ref_valid;
   logic         ref_clear;
   d1_fields_t   ref_d1;
   instr_bytes_t ref_ir;
   addr_t        ref_eip;
   sel_t         ref_cs;
   d2_out_t      out_q;
   logic         out_valid_q;
   logic         stall_q;

   addr_t        exp_eip;
   addr_t        exp_disp;
   addr_t        exp_imm;
   offset_t      exp_offset;
   seg_id_t      exp_seg1;
   reg_id_t      exp_base;
   logic         live;
   logic         mem_form;
   logic         reg_form;
   logic         is_movq;
   logic         is_cmpx;
   logic         is_grp1;
   logic         mod_op;
   logic         rm_op;

   decode_stage2 dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .stall     (stall),
      .d1        (d1),
      .ir        (ir),
      .eip       (eip),
      .cs        (cs),
      .out       (out),
      .out_valid (out_valid)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic roll(output logic [31:0] r);
      seed = xorshift32(seed);
      r = seed;
   endtask

   function automatic logic [15:0] pick_opcode(input logic [3:0] k);
      case (k)
         4'd0:    return {8'h00, OP_ADD_RM};
         4'd1:    return {8'h00, OP_MOV_RM};
         4'd2:    return {8'h00, OP_PUSH_ES};
         4'd3:    return 16'h0007;
         4'd4:    return 16'h000E;
         4'd5:    return 16'h0016;
         4'd6:    return 16'h0017;
         4'd7:    return 16'h001E;
         4'd8:    return {8'h00, OP_POP_DS};
         4'd9:    return {8'h00, OP_JMP_FAR};
         4'd10:   return {OP_ESC, OP_MOVQ};
         4'd11:   return {OP_ESC, OP_CMPXCHG};
         4'd12:   return {OP_ESC, 8'hB1};
         4'd13:   return {OP_ESC, OP_MOVQ};
         default: return {8'h00, OP_GRP1};
      endcase
   endfunction

   // bytes past the 16-byte window read as zero
   function automatic logic [7:0] window_byte(input instr_bytes_t w, input int idx);
      if (idx < 16) begin
         return w[8*idx +: 8];
      end
      return 8'h00;
   endfunction

   function automatic addr_t calc_disp(input d1_fields_t f, input instr_bytes_t w);
      int s;
      logic [7:0] b0;
      s = int'(f.disp_sel);
      b0 = window_byte(w, s);
      if (!f.disp_present) begin
         return '0;
      end
      if (f.disp_size) begin
         return {window_byte(w, s + 3), window_byte(w, s + 2),
                 window_byte(w, s + 1), b0};
      end
      return {{24{b0[7]}}, b0};
   endfunction

   function automatic addr_t calc_imm(input d1_fields_t f, input instr_bytes_t w);
      int s;
      logic [7:0] b0;
      logic [7:0] b1;
      s = int'(f.imm_sel);
      b0 = window_byte(w, s);
      b1 = window_byte(w, s + 1);
      if (f.imm_size == 2'd0) begin
         return {{24{b0[7]}}, b0};
      end
      if (f.imm_size == 2'd1) begin
         return {{16{b1[7]}}, b1, b0};
      end
      return {window_byte(w, s + 3), window_byte(w, s + 2), b1, b0};
   endfunction

   function automatic offset_t calc_offset(input d1_fields_t f, input instr_bytes_t w);
      int s;
      s = int'(f.offset_sel);
      if (f.offset_size == 2'd0) begin
         return '0;
      end
      // selector bytes 4 and 5 sit above the 32-bit offset
      return {window_byte(w, s + 5), window_byte(w, s + 4), window_byte(w, s + 3),
              window_byte(w, s + 2), window_byte(w, s + 1), window_byte(w, s)};
   endfunction

   function automatic seg_id_t calc_seg(input d1_fields_t f);
      logic [1:0] m;
      logic       stack;
      m = f.modrm[7:6];
      stack = (f.modrm_present && (m == 2'b01 || m == 2'b10) && f.modrm[2:0] == 3'b101)
              || (f.sib_present && f.sib[2:0] == 3'b100);
      if (f.segment_override) begin
         return f.seg_id;
      end
      if (!f.opcode_size
          && f.opcode[7:0] inside {8'h06, 8'h07, 8'h0E, 8'h16, 8'h17, 8'h1E, 8'h1F}) begin
         return f.opcode[5:3];
      end
      if (stack) begin
         return SEG_SS;
      end
      return SEG_DS;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("error %0t: %s", $time, msg);
      $display("Checks failed");
      $fatal(1, "stopping at the first failed check");
   endtask

   task automatic drive_instr(output logic hold);
      logic [31:0]  r0;
      logic [31:0]  r1;
      logic [31:0]  r2;
      d1_fields_t   f;
      instr_bytes_t w;
      logic [15:0]  op;
      roll(r0);
      roll(r1);
      roll(r2);
      op = pick_opcode(r0[3:0]);
      f = '0;
      f.opcode           = op;
      f.opcode_size      = (op[15:8] == OP_ESC);
      f.operand_override = (r0[6:4] == 3'd0);
      f.segment_override = (r0[8:7] == 2'd0);
      f.seg_id           = seg_id_t'(r0[11:9] % 3'd6);
      f.modrm_present    = (r0[13:12] != 2'd0);
      f.modrm            = r1[7:0];
      f.sib_present      = r0[14];
      f.sib              = r1[15:8];
      f.disp_present     = r0[15];
      f.disp_size        = r0[16];
      f.disp_sel         = r0[19:17];
      f.imm_size         = (r0[21:20] == 2'd3) ? 2'd2 : r0[21:20];
      f.imm_sel          = r1[19:16];
      f.offset_sel       = r1[22:20];
      f.offset_size      = r1[24:23];
      f.instr_length     = r1[28:25];
      for (int i = 0; i < 4; i++) begin
         roll(w[32*i +: 32]);
      end
      d1 <= f;
      ir <= w;
      // push some eips close to the wrap point
      eip <= (r2[2:0] == 3'd0) ? (32'hffff_fff0 | {28'd0, r2[6:3]}) : r1 ^ r2;
      cs <= r2[23:8];
      in_valid <= (r2[26:24] != 3'd0);
      hold = (r2[28:27] == 2'd0);
      stall <= hold;
   endtask

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ref_valid <= 1'b0;
         ref_clear <= 1'b1;
         ref_d1    <= '0;
         ref_ir    <= '0;
         ref_eip   <= '0;
         ref_cs    <= '0;
      end else if (!stall) begin
         ref_valid <= in_valid;
         ref_clear <= 1'b0;
         ref_d1    <= d1;
         ref_ir    <= ir;
         ref_eip   <= eip;
         ref_cs    <= cs;
      end
   end

   always_ff @(posedge clk) begin
      cyc         <= cyc + 1;
      out_q       <= out;
      out_valid_q <= out_valid;
      stall_q     <= stall;
      if (arst_n && !stall && in_valid) begin
         checked <= checked + 1;
      end
   end

   always_comb begin
      exp_eip    = ref_eip + {28'd0, ref_d1.instr_length};
      exp_disp   = calc_disp(ref_d1, ref_ir);
      exp_imm    = calc_imm(ref_d1, ref_ir);
      exp_offset = calc_offset(ref_d1, ref_ir);
      exp_seg1   = calc_seg(ref_d1);
      exp_base   = ref_d1.sib_present ? ref_d1.sib[2:0] : ref_d1.modrm[2:0];
      live       = (cyc > 0) && ref_valid;
      mem_form   = (ref_d1.modrm[7:6] != 2'b11);
      reg_form   = (ref_d1.modrm[7:6] == 2'b11);
      is_movq    = (ref_d1.opcode == 16'h0F7F);
      is_cmpx    = (ref_d1.opcode == 16'h0FB0) || (ref_d1.opcode == 16'h0FB1);
      is_grp1    = (ref_d1.opcode == 16'h0081);
      mod_op     = is_cmpx || ref_d1.opcode inside {16'h0001, 16'h0081};
      // opcodes with a real r/m operand
      rm_op      = is_movq || is_cmpx || ref_d1.opcode inside {16'h0001, 16'h0081, 16'h0089};
   end

   a_reset: assert property (@(posedge clk) (cyc > 0 && ref_clear)
         |-> (!out_valid && out.ctrl == '0))
      else stop_on_error("latch not cleared after reset");
   a_valid: assert property (@(posedge clk) (cyc > 0) |-> (out_valid == ref_valid))
      else stop_on_error("out_valid does not follow the accepted in_valid");
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
         (cyc > 1 && stall_q) |-> (out == out_q && out_valid == out_valid_q))
      else stop_on_error("latch changed while stalled");
   a_eip: assert property (@(posedge clk) live |-> (out.eip == exp_eip && out.cs == ref_cs))
      else stop_on_error("eip or cs mismatch");
   a_fields: assert property (@(posedge clk) live
         |-> (out.disp32 == exp_disp && out.imm32 == exp_imm && out.offset == exp_offset))
      else stop_on_error("displacement, immediate or offset mismatch");
   a_seg: assert property (@(posedge clk) live |-> (out.ctrl.seg1 == exp_seg1))
      else stop_on_error("seg1 mismatch");
   a_modform: assert property (@(posedge clk) (live && mod_op)
         |-> (out.ctrl.mem_rd == mem_form && out.ctrl.mem_wr == mem_form
              && out.ctrl.ld_gpr1 == reg_form))
      else stop_on_error("mem_rd, mem_wr or ld_gpr1 wrong for the modrm form");
   a_regop: assert property (@(posedge clk) (live && rm_op)
         |-> (out.ctrl.seg1_needed == mem_form
              && (is_grp1 || out.ctrl.sr2 == ref_d1.modrm[5:3])))
      else stop_on_error("seg1_needed or sr2 wrong for an r/m opcode");
   a_aluk: assert property (@(posedge clk) (live && is_grp1)
         |-> (out.ctrl.aluk == ref_d1.modrm[5:3]))
      else stop_on_error("aluk not taken from the reg field");
   a_sr1: assert property (@(posedge clk) (live && rm_op) |-> (out.ctrl.sr1 == exp_base))
      else stop_on_error("sr1 not the sib base or rm");
   a_base: assert property (@(posedge clk) live
         |-> (out.ctrl.base_reg_en == (ref_d1.modrm[7:6] == 2'b00
                                       && ref_d1.modrm[2:0] == 3'b101)))
      else stop_on_error("base_reg_en mismatch");
   a_movq: assert property (@(posedge clk) (live && is_movq)
         |-> (out.ctrl.ld_mm == reg_form && !out.ctrl.mm1_needed
              && out.ctrl.sr1_needed == mem_form))
      else stop_on_error("movq ld_mm, mm1_needed or sr1_needed wrong");
   a_cmpx: assert property (@(posedge clk) live |-> (out.ctrl.cmpxchg == is_cmpx))
      else stop_on_error("cmpxchg flag mismatch");
   a_size: assert property (@(posedge clk) (live && ref_d1.operand_override)
         |-> (out.ctrl.data_size == DSIZE_16))
      else stop_on_error("data_size not 16-bit under operand override");
   a_misc: assert property (@(posedge clk) live
         |-> (out.ctrl.sib_en == ref_d1.sib_present && out.ctrl.disp_en == ref_d1.disp_present
              && out.ctrl.sib_scale == ref_d1.sib[7:6] && out.ctrl.sr3 == ref_d1.modrm[5:3]
              && out.ctrl.sr4 == ref_d1.sib[5:3]
              && out.ctrl.mux_seg == (ref_d1.segment_override && ref_d1.seg_id == SEG_CS)))
      else stop_on_error("sib, disp, sr3, sr4 or mux_seg mismatch");

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the instruction stream finished");
      $display("Checks failed");
      $fatal(1, "run stopped by the watchdog");
   end

   initial begin
      logic hold;
      clk      = 1'b0;
      arst_n   = 1'b0;
      in_valid = 1'b0;
      stall    = 1'b1;
      d1       = '0;
      ir       = '0;
      eip      = '0;
      cs       = '0;
      seed     = 32'he11a;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      // keep stall up so the cleared latch stays visible
      repeat (2) @(posedge clk);
      for (int i = 0; i < N_INSTR; i++) begin
         drive_instr(hold);
         @(posedge clk);
         if (hold) begin
            stall <= 1'b0;
            @(posedge clk);
         end
      end
      // load one more valid instruction, then reset the filled latch
      in_valid <= 1'b1;
      stall    <= 1'b0;
      @(posedge clk);
      arst_n   <= 1'b0;
      in_valid <= 1'b0;
      stall    <= 1'b1;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);
      if (checked >= N_INSTR / 2) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("only %0d instructions were accepted", checked);
         $display("Checks failed");
         $fatal(1, "too few instructions reached the checks");
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
design/decode_pkg.sv
design/ucontrol_store.sv
design/field_extract.sv
design/segment_select.sv
design/decode_control.sv
design/d2_latch.sv
design/decode_stage2.sv
test/tb_decode_stage2.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_decode_stage2 -f vlog.f -o tb_decode_stage2 \
   && ./obj_dir/tb_decode_stage2 > sim.log 2>&1 \
   || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "^All checks passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
